//--- fetch_frontend.f
bpu_pkg.sv
bht.sv
btb.sv
bpu.sv
fetch_pc.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - bpu_pkg.sv
  - bht.sv
  - btb.sv
  - bpu.sv
  - fetch_pc.sv
  - fetch_frontend.sv
  - target: simulation
    files:
      - tb_fetch_frontend.sv

//--- tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend;

    import bpu_pkg::*;

    localparam int random_cycles = 2000;
    localparam int wait_limit    = 20;

    logic                 clk;
    logic                 reset;
    logic                 stall;
    logic [inst_w-1:0]    inst_1;
    logic [inst_w-1:0]    inst_2;
    logic                 inst_en_1;
    logic                 inst_en_2;
    logic                 branch_flush;
    logic [addr_w-1:0]    flush_target;
    logic                 update_en;
    logic [addr_w-1:0]    update_pc;
    logic                 update_taken;
    logic [addr_w-1:0]    update_target;
    logic [addr_w-1:0]    pc;
    logic                 is_branch_1;
    logic                 is_branch_2;
    logic                 pred_taken;
    logic [addr_w-1:0]    pred_target;
    logic                 fetch_en_1;
    logic                 fetch_en_2;

    // values applied at the next rising edge
    logic                 nxt_reset;
    logic                 nxt_stall;
    logic [inst_w-1:0]    nxt_inst_1;
    logic [inst_w-1:0]    nxt_inst_2;
    logic                 nxt_en_1;
    logic                 nxt_en_2;
    logic                 nxt_flush;
    logic [addr_w-1:0]    nxt_flush_target;
    logic                 nxt_update;
    logic [addr_w-1:0]    nxt_update_pc;
    logic                 nxt_update_taken;
    logic [addr_w-1:0]    nxt_update_target;

    // reference tables and pc
    counter_e             ref_ctr    [bht_depth];
    logic                 ref_valid  [btb_depth];
    logic [btb_tag_w-1:0] ref_tag    [btb_depth];
    logic [addr_w-1:0]    ref_target [btb_depth];
    logic [addr_w-1:0]    ref_pc;
    logic                 exp_taken;
    logic [addr_w-1:0]    exp_target;
    logic [31:0]          seed;
    logic [31:0]          r;
    logic [addr_w-1:0]    held_pc;

    localparam logic [addr_w-1:0] addr_a  = 32'h1c00_0100;
    localparam logic [addr_w-1:0] addr_b  = 32'h1c00_0200;
    localparam logic [addr_w-1:0] tgt_a   = 32'h1c00_2000;
    localparam logic [addr_w-1:0] tgt_b2  = 32'h1c00_3000;
    localparam logic [addr_w-1:0] tgt_b1  = 32'h1c00_3800;

    fetch_frontend UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic decodes_branch(input logic [inst_w-1:0] inst);
        return (inst[31:26] >= 6'h12) && (inst[31:26] <= 6'h1b);
    endfunction

    function automatic logic slot_predicts(input logic [addr_w-1:0] addr,
                                           input logic [inst_w-1:0] inst, input logic en);
        logic ctr;
        logic hit;
        ctr = ref_ctr[addr[9:2]] >= weak_taken;
        hit = ref_valid[addr[7:2]] && (ref_tag[addr[7:2]] == addr[31:8]);
        return decodes_branch(inst) && en && ctr && hit;
    endfunction

    function automatic logic [inst_w-1:0] make_inst(input logic [5:0] op);
        logic [31:0] rnd;
        rnd = next_random();
        return {op, rnd[25:0]};
    endfunction

    // branch opcode about half the time
    function automatic logic [inst_w-1:0] mixed_inst();
        logic [31:0] rnd;
        rnd = next_random();
        if (rnd[31]) begin
            return make_inst(6'h12 + 6'(rnd[30:27] % 10));
        end
        return make_inst(rnd[26:21]);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_val(input string name, input logic [addr_w-1:0] got,
                             input logic [addr_w-1:0] exp);
        assert (got === exp)
        else fail_now($sformatf("error: %s is %h, expected %h", name, got, exp));
    endtask

    task automatic set_idle();
        nxt_reset         = 1'b0;
        nxt_stall         = 1'b0;
        nxt_inst_1        = make_inst(6'h04);
        nxt_inst_2        = make_inst(6'h05);
        nxt_en_1          = 1'b1;
        nxt_en_2          = 1'b1;
        nxt_flush         = 1'b0;
        nxt_flush_target  = '0;
        nxt_update        = 1'b0;
        nxt_update_pc     = '0;
        nxt_update_taken  = 1'b0;
        nxt_update_target = '0;
    endtask

    task automatic reset_model();
        for (int i = 0; i < bht_depth; i++) begin
            ref_ctr[i] = weak_not_taken;
        end
        for (int i = 0; i < btb_depth; i++) begin
            ref_valid[i] = 1'b0;
        end
        ref_pc = reset_pc;
    endtask

    ////////////////////
    // expected outputs
    ////////////////////

    task automatic check_outputs();
        logic t1;
        logic t2;
        logic exp_en_1;
        logic exp_en_2;
        t1 = slot_predicts(ref_pc, inst_1, inst_en_1);
        t2 = slot_predicts(ref_pc + 32'd4, inst_2, inst_en_2);
        exp_taken  = 1'b0;
        exp_target = '0;
        exp_en_1   = inst_en_1;
        exp_en_2   = inst_en_2;
        if (reset || stall || branch_flush) begin
            exp_en_1 = 1'b0;
            exp_en_2 = 1'b0;
        end else if (t1) begin
            exp_taken  = 1'b1;
            exp_target = ref_target[ref_pc[7:2]];
            exp_en_2   = 1'b0;
        end else if (t2) begin
            exp_taken  = 1'b1;
            exp_target = ref_target[ref_pc[7:2] + 6'd1];
            exp_en_1   = 1'b1;
            exp_en_2   = 1'b1;
        end
        check_val("pc", pc, ref_pc);
        check_val("is_branch_1", is_branch_1, decodes_branch(inst_1));
        check_val("is_branch_2", is_branch_2, decodes_branch(inst_2));
        check_val("pred_taken", pred_taken, exp_taken);
        check_val("fetch_en_1", fetch_en_1, exp_en_1);
        check_val("fetch_en_2", fetch_en_2, exp_en_2);
        if (exp_taken) begin
            check_val("pred_target", pred_target, exp_target);
        end
    endtask

    // what the coming rising edge does to tables and pc
    task automatic advance_model();
        logic [bht_idx_w-1:0] ci;
        logic [btb_idx_w-1:0] bi;
        ci = update_pc[9:2];
        bi = update_pc[7:2];
        if (reset) begin
            reset_model();
        end else begin
            if (update_en) begin
                if (update_taken && ref_ctr[ci] != strong_taken) begin
                    ref_ctr[ci] = counter_e'(ref_ctr[ci] + 1);
                end else if (!update_taken && ref_ctr[ci] != strong_not_taken) begin
                    ref_ctr[ci] = counter_e'(ref_ctr[ci] - 1);
                end
                if (update_taken) begin
                    ref_valid[bi]  = 1'b1;
                    ref_tag[bi]    = update_pc[31:8];
                    ref_target[bi] = update_target;
                end
            end
            if (branch_flush) begin
                ref_pc = flush_target;
            end else if (!stall) begin
                ref_pc = exp_taken ? exp_target : ref_pc + 32'd8;
            end
        end
    endtask

    task automatic cycle();
        @(posedge clk);
        reset         <= nxt_reset;
        stall         <= nxt_stall;
        inst_1        <= nxt_inst_1;
        inst_2        <= nxt_inst_2;
        inst_en_1     <= nxt_en_1;
        inst_en_2     <= nxt_en_2;
        branch_flush  <= nxt_flush;
        flush_target  <= nxt_flush_target;
        update_en     <= nxt_update;
        update_pc     <= nxt_update_pc;
        update_taken  <= nxt_update_taken;
        update_target <= nxt_update_target;
        @(negedge clk);
        check_outputs();
        advance_model();
    endtask

    task automatic goto_pc(input logic [addr_w-1:0] addr);
        nxt_flush        = 1'b1;
        nxt_flush_target = addr;
        cycle();
        set_idle();
    endtask

    task automatic train(input logic [addr_w-1:0] addr, input logic taken,
                         input logic [addr_w-1:0] tgt);
        nxt_update        = 1'b1;
        nxt_update_pc     = addr;
        nxt_update_taken  = taken;
        nxt_update_target = tgt;
        cycle();
        set_idle();
    endtask

    task automatic wait_for_pc(input logic [addr_w-1:0] target, input string what);
        int n;
        n = 0;
        while (pc !== target) begin
            if (n == wait_limit) begin
                fail_now($sformatf("timeout waiting for %s", what));
            end
            cycle();
            n++;
        end
    endtask

    initial begin
        seed          = 32'hfb97_d7de;
        clk           = 1'b0;
        reset         = 1'b1;
        stall         = 1'b0;
        inst_1        = '0;
        inst_2        = '0;
        inst_en_1     = 1'b0;
        inst_en_2     = 1'b0;
        branch_flush  = 1'b0;
        flush_target  = '0;
        update_en     = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_target = '0;
        reset_model();
        set_idle();

        // reset and straight-line fetch
        nxt_reset = 1'b1;
        repeat (3) cycle();
        set_idle();
        cycle();
        check_val("pc", pc, reset_pc);
        for (int i = 0; i < 8; i++) begin
            nxt_en_1 = i[0];
            nxt_en_2 = i[1];
            cycle();
        end
        set_idle();

        ////////////////////
        // branch decode
        ////////////////////
        for (int op = 'h12; op <= 'h1b; op++) begin
            nxt_inst_1 = make_inst(6'(op));
            cycle();
            check_val("is_branch_1", is_branch_1, 1'b1);
            set_idle();
            nxt_inst_2 = make_inst(6'(op));
            cycle();
            check_val("is_branch_2", is_branch_2, 1'b1);
            set_idle();
        end
        nxt_inst_1 = make_inst(6'h11);
        nxt_inst_2 = make_inst(6'h1c);
        cycle();
        check_val("is_branch_1", is_branch_1, 1'b0);
        check_val("is_branch_2", is_branch_2, 1'b0);
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            nxt_inst_1 = make_inst(r[31:26]);
            nxt_inst_2 = make_inst(r[25:20]);
            cycle();
        end
        set_idle();

        // slot 1 redirect after two taken updates
        train(addr_a, 1'b1, tgt_a);
        train(addr_a, 1'b1, tgt_a);
        goto_pc(addr_a);
        nxt_inst_1 = make_inst(op_beq);
        cycle();
        check_val("pred_taken", pred_taken, 1'b1);
        check_val("fetch_en_2", fetch_en_2, 1'b0);
        set_idle();
        wait_for_pc(tgt_a, "slot 1 redirect");

        ////////////////////
        // slot 2 and priority
        ////////////////////
        train(addr_b + 32'd4, 1'b1, tgt_b2);
        train(addr_b + 32'd4, 1'b1, tgt_b2);
        goto_pc(addr_b);
        nxt_inst_2 = make_inst(op_bne);
        cycle();
        check_val("fetch_en_1", fetch_en_1, 1'b1);
        check_val("pred_target", pred_target, tgt_b2);
        set_idle();
        wait_for_pc(tgt_b2, "slot 2 redirect");
        train(addr_b, 1'b1, tgt_b1);
        train(addr_b, 1'b1, tgt_b1);
        goto_pc(addr_b);
        nxt_inst_1 = make_inst(op_b);
        nxt_inst_2 = make_inst(op_bl);
        cycle();
        check_val("pred_target", pred_target, tgt_b1);
        set_idle();
        // disabled slot 1 hands over to slot 2
        goto_pc(addr_b);
        nxt_inst_1 = make_inst(op_b);
        nxt_inst_2 = make_inst(op_bl);
        nxt_en_1   = 1'b0;
        cycle();
        check_val("pred_target", pred_target, tgt_b2);
        set_idle();
        goto_pc(addr_b);
        nxt_inst_1 = make_inst(op_b);
        nxt_inst_2 = make_inst(op_bl);
        nxt_en_1   = 1'b0;
        nxt_en_2   = 1'b0;
        cycle();
        check_val("pred_taken", pred_taken, 1'b0);
        set_idle();

        // four not-taken steps from the top end at strong not taken
        repeat (4) train(addr_a, 1'b0, '0);
        // one taken step back only reaches weak not taken
        train(addr_a, 1'b1, tgt_a);
        goto_pc(addr_a);
        nxt_inst_1 = make_inst(op_bge);
        cycle();
        check_val("pred_taken", pred_taken, 1'b0);
        set_idle();
        train(addr_a, 1'b1, tgt_a);
        goto_pc(addr_a);
        nxt_inst_1 = make_inst(op_bge);
        cycle();
        check_val("pred_taken", pred_taken, 1'b1);
        set_idle();

        // same index with another tag
        goto_pc(addr_a ^ 32'h0001_0000);
        nxt_inst_1 = make_inst(op_bge);
        cycle();
        check_val("pred_taken", pred_taken, 1'b0);
        set_idle();

        // stall over a predicted branch
        goto_pc(addr_a);
        nxt_stall  = 1'b1;
        nxt_inst_1 = make_inst(op_blt);
        cycle();
        held_pc = pc;
        cycle();
        cycle();
        check_val("pc", pc, held_pc);
        check_val("fetch_en_1", fetch_en_1, 1'b0);
        // flush wins over prediction and over stall
        nxt_stall = 1'b0;
        nxt_flush = 1'b1;
        nxt_flush_target = 32'h1c00_0400;
        cycle();
        set_idle();
        wait_for_pc(32'h1c00_0400, "flush over prediction");
        nxt_stall = 1'b1;
        nxt_flush = 1'b1;
        nxt_flush_target = 32'h1c00_0480;
        cycle();
        set_idle();
        wait_for_pc(32'h1c00_0480, "flush over stall");

        ////////////////////
        // random run
        ////////////////////
        for (int i = 0; i < random_cycles; i++) begin
            r = next_random();
            nxt_stall         = (r[31:29] == 3'd0);
            nxt_flush         = (r[28:25] == 4'd0);
            nxt_en_1          = r[24] | r[23];
            nxt_en_2          = r[22] | r[21];
            nxt_update        = r[20];
            nxt_update_taken  = r[19];
            // update window of eight words around the pc
            nxt_update_pc     = ref_pc + {27'd0, r[18:16], 2'b00} - 32'd8;
            nxt_inst_1        = mixed_inst();
            nxt_inst_2        = mixed_inst();
            r = next_random();
            nxt_flush_target  = reset_pc | {22'd0, r[31:25], 3'b000};
            nxt_update_target = reset_pc | {22'd0, r[24:18], 3'b000};
            cycle();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic [bpu_pkg::inst_w-1:0] inst_1,
    input  logic [bpu_pkg::inst_w-1:0] inst_2,
    input  logic                       inst_en_1,
    input  logic                       inst_en_2,
    input  logic                       branch_flush,
    input  logic [bpu_pkg::addr_w-1:0] flush_target,
    input  logic                       update_en,
    input  logic [bpu_pkg::addr_w-1:0] update_pc,
    input  logic                       update_taken,
    input  logic [bpu_pkg::addr_w-1:0] update_target,
    output logic [bpu_pkg::addr_w-1:0] pc,
    output logic                       is_branch_1,
    output logic                       is_branch_2,
    output logic                       pred_taken,
    output logic [bpu_pkg::addr_w-1:0] pred_target,
    output logic                       fetch_en_1,
    output logic                       fetch_en_2
);

    // redirect loops back from the predictor
    fetch_pc u_fetch_pc (
        .clk,
        .reset,
        .stall,
        .branch_flush,
        .flush_target,
        .pred_taken,
        .pred_target,
        .pc
    );

    bpu u_bpu (
        .clk,
        .reset,
        .stall,
        .branch_flush,
        .pc,
        .inst_1,
        .inst_2,
        .inst_en_1,
        .inst_en_2,
        .update_en,
        .update_pc,
        .update_taken,
        .update_target,
        .is_branch_1,
        .is_branch_2,
        .pred_taken,
        .pred_target,
        .fetch_en_1,
        .fetch_en_2
    );

endmodule

//--- fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       branch_flush,
    input  logic [bpu_pkg::addr_w-1:0] flush_target,
    input  logic                       pred_taken,
    input  logic [bpu_pkg::addr_w-1:0] pred_target,
    output logic [bpu_pkg::addr_w-1:0] pc
);

    import bpu_pkg::*;

    logic [addr_w-1:0] pc_next;

    ////////////////////
    // next pc select
    ////////////////////

    // flush beats stall, stall beats prediction
    always_comb begin
        if (branch_flush) begin
            pc_next = flush_target;
        end else if (stall) begin
            pc_next = pc;
        end else if (pred_taken) begin
            pc_next = pred_target;
        end else begin
            // two instructions per fetch
            pc_next = pc + addr_w'(8);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

//--- bpu.sv
`timescale 1ns/1ps

module bpu (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       branch_flush,
    input  logic [bpu_pkg::addr_w-1:0] pc,
    input  logic [bpu_pkg::inst_w-1:0] inst_1,
    input  logic [bpu_pkg::inst_w-1:0] inst_2,
    input  logic                       inst_en_1,
    input  logic                       inst_en_2,
    input  logic                       update_en,
    input  logic [bpu_pkg::addr_w-1:0] update_pc,
    input  logic                       update_taken,
    input  logic [bpu_pkg::addr_w-1:0] update_target,
    output logic                       is_branch_1,
    output logic                       is_branch_2,
    output logic                       pred_taken,
    output logic [bpu_pkg::addr_w-1:0] pred_target,
    output logic                       fetch_en_1,
    output logic                       fetch_en_2
);

    import bpu_pkg::*;

    logic [addr_w-1:0] pc_2;
    logic              ctr_taken_1;
    logic              ctr_taken_2;
    logic              hit_1;
    logic              hit_2;
    logic [addr_w-1:0] target_1;
    logic [addr_w-1:0] target_2;
    logic              slot_taken_1;
    logic              slot_taken_2;
    logic              gate;

    function automatic logic is_branch_op(input logic [op_w-1:0] op);
        case (branch_op_e'(op))
            op_bceqz, op_jirl, op_b, op_bl, op_beq,
            op_bne, op_blt, op_bge, op_bltu, op_bgeu: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////
    // decode
    ////////////////////

    // slot 2 is the word after slot 1
    assign pc_2 = pc + addr_w'(4);

    assign is_branch_1 = is_branch_op(inst_1[inst_w-1:inst_w-op_w]);
    assign is_branch_2 = is_branch_op(inst_2[inst_w-1:inst_w-op_w]);

    assign slot_taken_1 = is_branch_1 && inst_en_1 && ctr_taken_1 && hit_1;
    assign slot_taken_2 = is_branch_2 && inst_en_2 && ctr_taken_2 && hit_2;

    assign gate = reset || stall || branch_flush;

    ////////////////////
    // slot priority
    ////////////////////

    always_comb begin
        pred_target = '0;
        pred_taken  = 1'b0;
        fetch_en_1  = inst_en_1;
        fetch_en_2  = inst_en_2;
        if (slot_taken_1) begin
            // slot 2 is on the wrong path
            pred_target = target_1;
            pred_taken  = 1'b1;
            fetch_en_1  = 1'b1;
            fetch_en_2  = 1'b0;
        end else if (slot_taken_2) begin
            pred_target = target_2;
            pred_taken  = 1'b1;
            fetch_en_1  = 1'b1;
            fetch_en_2  = 1'b1;
        end
        if (gate) begin
            pred_taken = 1'b0;
            fetch_en_1 = 1'b0;
            fetch_en_2 = 1'b0;
        end
    end

    bht u_bht (
        .clk,
        .reset,
        .pc_1         (pc),
        .pc_2         (pc_2),
        .update_en,
        .update_pc,
        .update_taken,
        .taken_1      (ctr_taken_1),
        .taken_2      (ctr_taken_2)
    );

    btb u_btb (
        .clk,
        .reset,
        .pc_1         (pc),
        .pc_2         (pc_2),
        .update_en,
        .update_pc,
        .update_taken,
        .update_target,
        .hit_1,
        .hit_2,
        .target_1,
        .target_2
    );

endmodule

//--- btb.sv
`timescale 1ns/1ps

module btb (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [bpu_pkg::addr_w-1:0] pc_1,
    input  logic [bpu_pkg::addr_w-1:0] pc_2,
    input  logic                       update_en,
    input  logic [bpu_pkg::addr_w-1:0] update_pc,
    input  logic                       update_taken,
    input  logic [bpu_pkg::addr_w-1:0] update_target,
    output logic                       hit_1,
    output logic                       hit_2,
    output logic [bpu_pkg::addr_w-1:0] target_1,
    output logic [bpu_pkg::addr_w-1:0] target_2
);

    import bpu_pkg::*;

    logic                 valid   [btb_depth];
    logic [btb_tag_w-1:0] tags    [btb_depth];
    logic [addr_w-1:0]    targets [btb_depth];

    logic [btb_idx_w-1:0] idx_1;
    logic [btb_idx_w-1:0] idx_2;
    logic [btb_idx_w-1:0] upd_idx;
    logic [btb_tag_w-1:0] tag_1;
    logic [btb_tag_w-1:0] tag_2;
    logic [btb_tag_w-1:0] upd_tag;
    logic                 write_en;

    ////////////////////
    // address split
    ////////////////////

    assign idx_1   = pc_1[btb_idx_w+1:2];
    assign idx_2   = pc_2[btb_idx_w+1:2];
    assign upd_idx = update_pc[btb_idx_w+1:2];

    assign tag_1   = pc_1[addr_w-1:addr_w-btb_tag_w];
    assign tag_2   = pc_2[addr_w-1:addr_w-btb_tag_w];
    assign upd_tag = update_pc[addr_w-1:addr_w-btb_tag_w];

    // lookup, both slots in parallel
    assign hit_1    = valid[idx_1] && (tags[idx_1] == tag_1);
    assign hit_2    = valid[idx_2] && (tags[idx_2] == tag_2);
    assign target_1 = targets[idx_1];
    assign target_2 = targets[idx_2];

    // only taken branches allocate
    assign write_en = update_en && update_taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < btb_depth; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    // tag and target payload
    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[upd_idx]    <= upd_tag;
            targets[upd_idx] <= update_target;
        end
    end

endmodule

//--- bht.sv
`timescale 1ns/1ps

module bht (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [bpu_pkg::addr_w-1:0] pc_1,
    input  logic [bpu_pkg::addr_w-1:0] pc_2,
    input  logic                      update_en,
    input  logic [bpu_pkg::addr_w-1:0] update_pc,
    input  logic                      update_taken,
    output logic                      taken_1,
    output logic                      taken_2
);

    import bpu_pkg::*;

    counter_e counters [bht_depth];

    logic [bht_idx_w-1:0] idx_1;
    logic [bht_idx_w-1:0] idx_2;
    logic [bht_idx_w-1:0] upd_idx;
    counter_e             upd_cur;
    counter_e             upd_next;

    assign idx_1   = pc_1[bht_idx_w+1:2];
    assign idx_2   = pc_2[bht_idx_w+1:2];
    assign upd_idx = update_pc[bht_idx_w+1:2];

    // either taken state predicts taken
    assign taken_1 = (counters[idx_1] == weak_taken) || (counters[idx_1] == strong_taken);
    assign taken_2 = (counters[idx_2] == weak_taken) || (counters[idx_2] == strong_taken);

    ////////////////////
    // saturating step
    ////////////////////

    assign upd_cur = counters[upd_idx];

    always_comb begin
        case (upd_cur)
            strong_not_taken: upd_next = update_taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   upd_next = update_taken ? weak_taken : strong_not_taken;
            weak_taken:       upd_next = update_taken ? strong_taken : weak_not_taken;
            strong_taken:     upd_next = update_taken ? strong_taken : weak_taken;
            default:          upd_next = weak_not_taken;
        endcase
    end

    // reads in the update cycle still see the old entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < bht_depth; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (update_en) begin
            counters[upd_idx] <= upd_next;
        end
    end

endmodule

//--- bpu_pkg.sv
package bpu_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int inst_w = 32;
    localparam int addr_w = 32;

    // branch opcode sits in inst[31:26]
    localparam int op_w = 6;

    ////////////////////
    // table geometry
    ////////////////////

    // history table indexed by pc[9:2]
    localparam int bht_idx_w = 8;
    localparam int bht_depth = 1 << bht_idx_w;

    // target buffer indexed by pc[7:2], tag is pc[31:8]
    localparam int btb_idx_w = 6;
    localparam int btb_tag_w = 24;
    localparam int btb_depth = 1 << btb_idx_w;

    localparam logic [addr_w-1:0] reset_pc = 32'h1c00_0000;

    // conditional and unconditional branches, anything else is not a branch
    typedef enum logic [op_w-1:0] {
        op_bceqz = 6'h12,
        op_jirl  = 6'h13,
        op_b     = 6'h14,
        op_bl    = 6'h15,
        op_beq   = 6'h16,
        op_bne   = 6'h17,
        op_blt   = 6'h18,
        op_bge   = 6'h19,
        op_bltu  = 6'h1a,
        op_bgeu  = 6'h1b
    } branch_op_e;

    // two-bit saturating counter, msb set means taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_e;

endpackage
